// ==== gateway_tag_top.f ====
hw/gateway_tag_pkg.sv
hw/tag_trace_replay.sv
hw/tag_client.sv
hw/tag_report_collector.sv
hw/gateway_tag_top.sv
verification/tb_clock_gen.sv
verification/tb_gateway_tag.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the gateway tag testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_gateway_tag \
  -f gateway_tag_top.f \
  -o sim_gateway_tag

# The testbench stops with a non-zero status on failure; the log decides
./obj_dir/sim_gateway_tag > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Result: passed"
else
  echo "Result: failed"
  exit 1
fi

// ==== verification/tb_gateway_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gateway_tag;

  import gateway_tag_pkg::*;

  localparam int NUM_CLIENTS = 4;
  localparam int MAX_ROWS    = 32;
  localparam int MAX_RPTS    = 32;

  // One line of the test table
  typedef struct packed
  {
    tag_cmd_s                       cmd;
    logic                           hold;      // report ack withheld during this row
    logic [2:0]                     req_hold;  // cycles the host keeps req up after ack
    tag_payload_s [NUM_CLIENTS-1:0] exp_cfg;
    logic [7:0]                     rpt_end;   // reports expected up to this row
  } row_s;

  logic                           clk;
  logic                           rst;
  tag_cmd_s                       cmd;
  logic                           cmd_req;
  logic                           cmd_ack;
  tag_payload_s [NUM_CLIENTS-1:0] cfg;
  tag_report_s                    rpt;
  logic                           rpt_req;
  logic                           rpt_ack;

  row_s        rows [MAX_ROWS];
  string       row_names [MAX_ROWS];
  int          num_rows;
  tag_report_s exp_rpts [MAX_RPTS];
  string       exp_rpt_names [MAX_RPTS];
  int          num_exp_rpts;

  // Scoreboard state
  tag_payload_s [NUM_CLIENTS-1:0] model_cfg;
  logic [NUM_CLIENTS-1:0]         model_pending;
  logic                           model_busy;

  int   seed = 71;
  int   rpt_idx;
  int   rpt_allowed;
  logic rpt_hold;
  int   cycles;
  int   cycle_limit;

  tb_clock_gen i_tb_clock_gen
    (.clk_o (clk)
    );

  gateway_tag_top
    #(.NUM_CLIENTS_P (NUM_CLIENTS))
    i_gateway_tag_top
      (.clk_i     (clk)
      ,.rst_i     (rst)
      ,.cmd_i     (cmd)
      ,.cmd_req_i (cmd_req)
      ,.cmd_ack_o (cmd_ack)
      ,.cfg_o     (cfg)
      ,.rpt_o     (rpt)
      ,.rpt_req_o (rpt_req)
      ,.rpt_ack_i (rpt_ack)
      );

  //////////////////////////////
  // Error reporting

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    stop_on_error($sformatf("FAIL %s: expected %0h, actual %0h", name, exp, act));
  endtask

  //////////////////////////////
  // Table and scoreboard

  function automatic tag_payload_s random_payload();
    return tag_payload_s'(9'($random(seed)));
  endfunction

  task automatic push_report(input string name, input int client);
    tag_report_s rec;
    rec.client                  = TAG_ID_W'(client);
    rec.payload                 = model_cfg[client];
    exp_rpts[num_exp_rpts]      = rec;
    exp_rpt_names[num_exp_rpts] = name;
    num_exp_rpts++;
  endtask

  task automatic add_row
    (input string        name
    ,input tag_op_e      op
    ,input int           client
    ,input tag_payload_s payload
    ,input logic         hold
    );
    row_s r;
    // Release drains the report in flight, then pending clients by index
    if (!hold && model_busy)
    begin
      model_busy = 1'b0;
      for (int i = 0; i < NUM_CLIENTS; i++)
      begin
        if (model_pending[i])
        begin
          push_report(name, i);
          model_pending[i] = 1'b0;
        end
      end
    end
    if (op == e_tag_clear)
    begin
      for (int i = 0; i < NUM_CLIENTS; i++)
      begin
        model_cfg[i] = TAG_PAYLOAD_DEFAULT;
      end
    end
    else if (client < NUM_CLIENTS)
    begin
      model_cfg[client] = payload;
      if (model_busy)
      begin
        model_pending[client] = 1'b1;
      end
      else
      begin
        push_report(name, client);
        model_busy = hold;
      end
    end
    r.cmd.op          = op;
    r.cmd.client      = TAG_ID_W'(client);
    r.cmd.payload     = payload;
    r.hold            = hold;
    r.req_hold        = 3'($random(seed));
    r.exp_cfg         = model_cfg;
    r.rpt_end         = 8'(num_exp_rpts);
    rows[num_rows]      = r;
    row_names[num_rows] = name;
    num_rows++;
  endtask

  task automatic build_table();
    num_rows      = 0;
    num_exp_rpts  = 0;
    model_busy    = 1'b0;
    model_pending = '0;
    for (int i = 0; i < NUM_CLIENTS; i++)
    begin
      model_cfg[i] = TAG_PAYLOAD_DEFAULT;
    end
    for (int i = 0; i < NUM_CLIENTS; i++)
    begin
      add_row($sformatf("write_client_%0d", i), e_tag_write, i, random_payload(), 1'b0);
    end
    add_row("rewrite_client_2", e_tag_write, 2, random_payload(), 1'b0);
    add_row("clear_all", e_tag_clear, 0, TAG_PAYLOAD_DEFAULT, 1'b0);
    add_row("write_after_clear", e_tag_write, 1, random_payload(), 1'b0);
    add_row("write_index_4", e_tag_write, 4, random_payload(), 1'b0);
    add_row("write_index_15", e_tag_write, 15, random_payload(), 1'b0);
    // Client 0 report sits in flight, the rest queue behind it
    add_row("held_client_0", e_tag_write, 0, random_payload(), 1'b1);
    add_row("held_client_2_first", e_tag_write, 2, random_payload(), 1'b1);
    add_row("held_client_2_second", e_tag_write, 2, random_payload(), 1'b1);
    add_row("held_client_3", e_tag_write, 3, random_payload(), 1'b1);
    add_row("held_client_1", e_tag_write, 1, random_payload(), 1'b1);
    add_row("release_index_9", e_tag_write, 9, random_payload(), 1'b0);
    add_row("clear_final", e_tag_clear, 0, TAG_PAYLOAD_DEFAULT, 1'b0);
  endtask

  //////////////////////////////
  // Host command driver

  task automatic send_cmd(input int r);
    string name;
    name = row_names[r];
    @(negedge clk);
    assert (!cmd_ack)
      else stop_on_error("command ack still high before a new request");
    @(posedge clk);
    cmd     <= rows[r].cmd;
    cmd_req <= 1'b1;
    @(negedge clk);
    while (!cmd_ack)
    begin
      @(negedge clk);
    end
    // Clients update no later than the ack
    assert (cfg == rows[r].exp_cfg)
      else fail_value({name, " cfg at ack"}, 64'(rows[r].exp_cfg), 64'(cfg));
    repeat (rows[r].req_hold)
    begin
      @(negedge clk);
      assert (cmd_ack)
        else stop_on_error("command ack fell while req was still high");
    end
    @(posedge clk);
    cmd_req <= 1'b0;
    @(negedge clk);
    while (cmd_ack)
    begin
      @(negedge clk);
    end
    assert (cfg == rows[r].exp_cfg)
      else fail_value({name, " cfg after handshake"}, 64'(rows[r].exp_cfg), 64'(cfg));
  endtask

  //////////////////////////////
  // Report responder

  initial
  begin : report_responder
    int          delay;
    tag_report_s seen;
    forever
    begin
      @(negedge clk);
      if (!rst && rpt_req === 1'b1)
      begin
        assert (rpt_idx < rpt_allowed)
          else stop_on_error("collector raised a report that no write called for");
        seen = rpt;
        assert (seen == exp_rpts[rpt_idx])
          else fail_value({exp_rpt_names[rpt_idx], " report"},
                          64'(exp_rpts[rpt_idx]), 64'(seen));
        delay = $random(seed) & 7;
        while (rpt_hold || delay > 0)
        begin
          if (!rpt_hold)
          begin
            delay--;
          end
          @(negedge clk);
          assert (rpt_req && rpt == seen)
            else stop_on_error("report request or data changed before the ack");
        end
        @(posedge clk);
        rpt_ack <= 1'b1;
        @(negedge clk);
        while (rpt_req)
        begin
          @(negedge clk);
        end
        @(posedge clk);
        rpt_ack <= 1'b0;
        rpt_idx++;
      end
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      stop_on_error("timeout waiting for handshake");
    end
  end

  //////////////////////////////
  // Main sequence

  initial
  begin : main
    rst         = 1'b1;
    cmd         = '0;
    cmd_req     = 1'b0;
    rpt_ack     = 1'b0;
    rpt_hold    = 1'b0;
    rpt_idx     = 0;
    rpt_allowed = 0;
    cycles      = 0;
    build_table();
    cycle_limit = 64 * num_rows + 200;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    for (int i = 0; i < NUM_CLIENTS; i++)
    begin
      assert (cfg[i] == TAG_PAYLOAD_DEFAULT)
        else fail_value($sformatf("reset cfg client %0d", i),
                        64'(TAG_PAYLOAD_DEFAULT), 64'(cfg[i]));
    end
    assert (!rpt_req && !cmd_ack)
      else stop_on_error("handshake outputs not low after reset");

    for (int r = 0; r < num_rows; r++)
    begin
      rpt_hold    <= rows[r].hold;
      rpt_allowed <= int'(rows[r].rpt_end);
      send_cmd(r);
      if (!rows[r].hold)
      begin
        while (rpt_idx < int'(rows[r].rpt_end))
        begin
          @(negedge clk);
        end
      end
    end

    // Quiet tail to catch late reports
    repeat (20) @(negedge clk);
    assert (cfg == model_cfg)
      else fail_value("final cfg", 64'(model_cfg), 64'(cfg));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
  #(parameter int HALF_PERIOD_P = 50)
  (output logic clk_o
  );

  // 100 ns period
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(HALF_PERIOD_P);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== hw/gateway_tag_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gateway_tag_top
  #(parameter int NUM_CLIENTS_P = 4)
  (input  logic                                              clk_i
  ,input  logic                                              rst_i

  ,input  gateway_tag_pkg::tag_cmd_s                         cmd_i
  ,input  logic                                              cmd_req_i
  ,output logic                                              cmd_ack_o

  ,output gateway_tag_pkg::tag_payload_s [NUM_CLIENTS_P-1:0] cfg_o

  ,output gateway_tag_pkg::tag_report_s                      rpt_o
  ,output logic                                              rpt_req_o
  ,input  logic                                              rpt_ack_i
  );

  logic                     tag_line;
  logic [NUM_CLIENTS_P-1:0] wr_pulse;

  //////////////////////////////
  // Command replay

  tag_trace_replay i_tag_trace_replay
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.cmd_i      (cmd_i)
    ,.cmd_req_i  (cmd_req_i)
    ,.cmd_ack_o  (cmd_ack_o)
    ,.tag_line_o (tag_line)
    );

  //////////////////////////////
  // One client per destination

  for (genvar i = 0; i < NUM_CLIENTS_P; i++)
  begin : g_client
    tag_client
      #(.CLIENT_ID_P (i))
      i_tag_client
        (.clk_i      (clk_i)
        ,.rst_i      (rst_i)
        ,.tag_line_i (tag_line)
        ,.cfg_o      (cfg_o[i])
        ,.wr_pulse_o (wr_pulse[i])
        );
  end

  //////////////////////////////
  // Write reports

  tag_report_collector
    #(.NUM_CLIENTS_P (NUM_CLIENTS_P))
    i_tag_report_collector
      (.clk_i      (clk_i)
      ,.rst_i      (rst_i)
      ,.wr_pulse_i (wr_pulse)
      ,.cfg_i      (cfg_o)
      ,.rpt_o      (rpt_o)
      ,.rpt_req_o  (rpt_req_o)
      ,.rpt_ack_i  (rpt_ack_i)
      );

endmodule

`default_nettype wire

// ==== hw/tag_report_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_report_collector
  #(parameter int NUM_CLIENTS_P = 4)
  (input  logic                                              clk_i
  ,input  logic                                              rst_i

  ,input  logic [NUM_CLIENTS_P-1:0]                          wr_pulse_i
  ,input  gateway_tag_pkg::tag_payload_s [NUM_CLIENTS_P-1:0] cfg_i

  ,output gateway_tag_pkg::tag_report_s                      rpt_o
  ,output logic                                              rpt_req_o
  ,input  logic                                              rpt_ack_i
  );

  import gateway_tag_pkg::*;

  tag_collect_state_e state_r;
  tag_collect_state_e state_n;

  logic [NUM_CLIENTS_P-1:0] pending_r;
  logic [NUM_CLIENTS_P-1:0] pick_onehot;
  logic                     pick_v;
  logic                     take;
  tag_report_s              pick_rpt;
  tag_report_s              rpt_r;

  //////////////////////////////
  // Lowest index first

  always_comb
  begin
    pick_onehot = '0;
    pick_rpt    = '0;
    for (int i = NUM_CLIENTS_P - 1; i >= 0; i--)
    begin
      if (pending_r[i])
      begin
        pick_onehot      = '0;
        pick_onehot[i]   = 1'b1;
        pick_rpt.client  = TAG_ID_W'(i);
        pick_rpt.payload = cfg_i[i];
      end
    end
  end

  assign pick_v = |pending_r;
  assign take   = (state_r == e_collect_idle) & pick_v;

  //////////////////////////////
  // Report handshake

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_collect_idle:
      begin
        if (pick_v)
        begin
          state_n = e_collect_req_high;
        end
      end
      e_collect_req_high:
      begin
        if (rpt_ack_i)
        begin
          state_n = e_collect_wait_ack_low;
        end
      end
      e_collect_wait_ack_low:
      begin
        if (!rpt_ack_i)
        begin
          state_n = e_collect_idle;
        end
      end
      default:
      begin
        state_n = e_collect_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r   <= e_collect_idle;
      pending_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      // Repeat writes fold into one flag, the report reads the latest cfg
      pending_r <= (pending_r | wr_pulse_i) & ~(take ? pick_onehot : '0);
    end
  end

  // Held steady until the next pick
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      rpt_r <= pick_rpt;
    end
  end

  assign rpt_o     = rpt_r;
  assign rpt_req_o = (state_r == e_collect_req_high);

endmodule

`default_nettype wire

// ==== hw/tag_client.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_client
  #(parameter int CLIENT_ID_P = 0)
  (input  logic                          clk_i
  ,input  logic                          rst_i

  ,input  logic                          tag_line_i

  ,output gateway_tag_pkg::tag_payload_s cfg_o
  ,output logic                          wr_pulse_o
  );

  import gateway_tag_pkg::*;

  logic                     busy_r;
  logic [TAG_CNT_W-1:0]     cnt_r;
  logic [TAG_FRAME_LEN-3:0] shift_r;
  tag_cmd_s                 frame;
  logic                     frame_done;
  tag_payload_s             cfg_r;
  logic                     wr_pulse_r;

  // Last bit is taken straight from the line
  assign frame      = tag_cmd_s'({shift_r, tag_line_i});
  assign frame_done = busy_r & (cnt_r == TAG_CNT_W'(TAG_FRAME_LEN - 2));

  always_ff @(posedge clk_i)
  begin
    if (busy_r)
    begin
      shift_r <= {shift_r[TAG_FRAME_LEN-4:0], tag_line_i};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r     <= 1'b0;
      cnt_r      <= '0;
      cfg_r      <= TAG_PAYLOAD_DEFAULT;
      wr_pulse_r <= 1'b0;
    end
    else
    begin
      wr_pulse_r <= 1'b0;
      if (!busy_r)
      begin
        // Start bit
        if (tag_line_i)
        begin
          busy_r <= 1'b1;
          cnt_r  <= '0;
        end
      end
      else
      begin
        cnt_r <= cnt_r + 1'b1;
        if (frame_done)
        begin
          busy_r <= 1'b0;
          if (frame.op == e_tag_clear)
          begin
            cfg_r <= TAG_PAYLOAD_DEFAULT;
          end
          else if (frame.client == TAG_ID_W'(CLIENT_ID_P))
          begin
            cfg_r      <= frame.payload;
            wr_pulse_r <= 1'b1;
          end
        end
      end
    end
  end

  assign cfg_o      = cfg_r;
  assign wr_pulse_o = wr_pulse_r;

endmodule

`default_nettype wire

// ==== hw/tag_trace_replay.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_trace_replay
  (input  logic                      clk_i
  ,input  logic                      rst_i

  ,input  gateway_tag_pkg::tag_cmd_s cmd_i
  ,input  logic                      cmd_req_i
  ,output logic                      cmd_ack_o

  ,output logic                      tag_line_o
  );

  import gateway_tag_pkg::*;

  tag_replay_state_e state_r;
  tag_replay_state_e state_n;

  logic [TAG_FRAME_LEN-1:0] shift_r;
  logic [TAG_CNT_W-1:0]     cnt_r;
  logic                     last_bit;

  // Bit on the line this cycle is the final one of the frame
  assign last_bit = (cnt_r == TAG_CNT_W'(TAG_FRAME_LEN - 1));

  //////////////////////////////
  // Handshake FSM

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_replay_idle:
      begin
        if (cmd_req_i)
        begin
          state_n = e_replay_shift;
        end
      end
      e_replay_shift:
      begin
        if (last_bit)
        begin
          state_n = e_replay_ack_hold;
        end
      end
      e_replay_ack_hold:
      begin
        // Wait for the host to release req
        if (!cmd_req_i)
        begin
          state_n = e_replay_idle;
        end
      end
      default:
      begin
        state_n = e_replay_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= e_replay_idle;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  //////////////////////////////
  // Frame shifter

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      shift_r <= '0;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        e_replay_idle:
        begin
          if (cmd_req_i)
          begin
            shift_r <= {1'b1, cmd_i};
            cnt_r   <= '0;
          end
        end
        e_replay_shift:
        begin
          // Zeros fill in behind, so the line idles low after the frame
          shift_r <= {shift_r[TAG_FRAME_LEN-2:0], 1'b0};
          cnt_r   <= cnt_r + 1'b1;
        end
        default:
        begin
          cnt_r <= '0;
        end
      endcase
    end
  end

  assign tag_line_o = shift_r[TAG_FRAME_LEN-1];
  assign cmd_ack_o  = (state_r == e_replay_ack_hold);

endmodule

`default_nettype wire

// ==== hw/gateway_tag_pkg.sv ====
`default_nettype none

package gateway_tag_pkg;

  //////////////////////////////
  // Widths

  localparam int TAG_DID_W = 8;
  localparam int TAG_ID_W  = 4;

  typedef enum logic
  {
    e_tag_write = 1'b0
    ,e_tag_clear = 1'b1
  } tag_op_e;

  // Control word of one client
  typedef struct packed
  {
    logic                 reset;
    logic [TAG_DID_W-1:0] did;
  } tag_payload_s;

  localparam tag_payload_s TAG_PAYLOAD_DEFAULT = '{reset: 1'b1, did: '0};

  typedef struct packed
  {
    tag_op_e             op;
    logic [TAG_ID_W-1:0] client;
    tag_payload_s        payload;
  } tag_cmd_s;

  typedef struct packed
  {
    logic [TAG_ID_W-1:0] client;
    tag_payload_s        payload;
  } tag_report_s;

  // Start bit, then the whole command
  localparam int TAG_FRAME_LEN = 1 + $bits(tag_cmd_s);
  localparam int TAG_CNT_W     = $clog2(TAG_FRAME_LEN);

  //////////////////////////////
  // FSM states

  typedef enum logic [1:0]
  {
    e_replay_idle
    ,e_replay_shift
    ,e_replay_ack_hold
  } tag_replay_state_e;

  typedef enum logic [1:0]
  {
    e_collect_idle
    ,e_collect_req_high
    ,e_collect_wait_ack_low
  } tag_collect_state_e;

endpackage

`default_nettype wire
